// ==== verilog/pcie_fc_pkg.sv ====
// credit limits are cumulative 16-bit values that wrap; slots 6 and 7 of the limit bus carry nothing
`default_nettype none

package pcie_fc_pkg;

    // every credit count, limit and debit uses this width
    localparam int FC_WIDTH = 16;

    // header and data classes for posted, non-posted and completion traffic
    localparam int FC_NUM_CLASSES = 6;

    // time slot of each class on the multiplexed limit bus
    localparam logic [2:0] FC_IDX_PH   = 3'd0;
    localparam logic [2:0] FC_IDX_PD   = 3'd1;
    localparam logic [2:0] FC_IDX_NPH  = 3'd2;
    localparam logic [2:0] FC_IDX_NPD  = 3'd3;
    localparam logic [2:0] FC_IDX_CPLH = 3'd4;
    localparam logic [2:0] FC_IDX_CPLD = 3'd5;

    // one data credit covers four dwords of payload
    localparam int FC_DW_PER_CREDIT = 4;

    // one word per credit class
    // the same layout carries available credits to the arbiter and debits back to the counters
    typedef struct packed {
        logic [FC_WIDTH-1:0] ph;
        logic [FC_WIDTH-1:0] pd;
        logic [FC_WIDTH-1:0] nph;
        logic [FC_WIDTH-1:0] npd;
        logic [FC_WIDTH-1:0] cplh;
        logic [FC_WIDTH-1:0] cpld;
    } fc_vec_t;

endpackage

`default_nettype wire

// ==== verilog/pcie_tlp_pkg.sv ====
// describes TLP requests only by length and tag; payload data and framing are not carried
`default_nettype none

package pcie_tlp_pkg;

    // posted, non-posted and completion sources share the transmit bus
    localparam int NUM_SRC = 3;

    // wide enough to index one of the sources
    localparam int SRC_IDX_WIDTH = 2;

    // request length in dwords and tag width
    localparam int TLP_LEN_WIDTH = 10;
    localparam int TLP_TAG_WIDTH = 8;

    // the source index is the same number as the kind
    typedef enum logic [SRC_IDX_WIDTH-1:0] {
        TLP_POSTED     = 2'd0,
        TLP_NON_POSTED = 2'd1,
        TLP_COMPLETION = 2'd2
    } tlp_kind_e;

    // a length of zero means the TLP has no data and needs no data credits
    typedef struct packed {
        logic [TLP_LEN_WIDTH-1:0] len;
        logic [TLP_TAG_WIDTH-1:0] tag;
    } tlp_desc_t;

    // one entry on the shared transmit bus, valid for a single cycle
    typedef struct packed {
        logic      valid;
        tlp_kind_e kind;
        tlp_desc_t desc;
    } tx_tlp_t;

endpackage

`default_nettype wire

// ==== verilog/tx_fc_counter.sv ====
// capacity latches on the first nonzero limit and holds until reset; a limit of zero never sets it
`timescale 1ns/100ps
`default_nettype none

module tx_fc_counter import pcie_fc_pkg::*; #(
    parameter logic [2:0] slot_index = 3'd0
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [FC_WIDTH-1:0] tx_cdts_limit,
    input  logic [2:0]          tx_cdts_limit_tdm_idx,
    input  logic [FC_WIDTH-1:0] fc_dec,
    output logic [FC_WIDTH-1:0] fc_av
);

    logic [FC_WIDTH-1:0]        cap_q;
    logic [FC_WIDTH-1:0]        limit_q;
    logic [FC_WIDTH-1:0]        inc_q;
    logic [FC_WIDTH-1:0]        av_q;
    logic                       slot_hit;
    // two guard bits so that count plus increment cannot wrap before the clamp
    logic signed [FC_WIDTH+1:0] sum;

    // the limit bus names the class it carries in every cycle
    assign slot_hit = (tx_cdts_limit_tdm_idx == slot_index);

    // new count before clamping, the debit of this cycle and the increment of the last slot
    assign sum = $signed({2'b00, av_q}) + $signed({2'b00, inc_q}) - $signed({2'b00, fc_dec});

    always_ff @(posedge clk) begin
        if (rst) begin
            cap_q   <= '0;
            limit_q <= '0;
            inc_q   <= '0;
            av_q    <= '0;
        end else begin
            if (slot_hit) begin
                // the very first limit also becomes the initial increment, filling the count
                if (cap_q == '0) begin
                    cap_q <= tx_cdts_limit;
                end
                // limits wrap, so the modulo difference is the real increase
                inc_q   <= tx_cdts_limit - limit_q;
                limit_q <= tx_cdts_limit;
            end else begin
                // an increase counts exactly once, in the cycle after its own slot
                inc_q <= '0;
            end

            // clamp to the range the link partner can actually have advertised
            if (sum < 0) begin
                av_q <= '0;
            end else if (sum > $signed({2'b00, cap_q})) begin
                av_q <= cap_q;
            end else begin
                av_q <= sum[FC_WIDTH-1:0];
            end
        end
    end

    assign fc_av = av_q;

    // the arbiter relies on the count staying inside the advertised capacity
    a_av_within_cap: assert property (@(posedge clk) disable iff (rst) av_q <= cap_q)
        else $error("credit count %0d above capacity %0d in slot %0d", av_q, cap_q, slot_index);

endmodule

`default_nettype wire

// ==== verilog/tx_tlp_arbiter.sv ====
// sources must hold request and descriptor until granted; the transmit bus has no back-pressure
`timescale 1ns/100ps
`default_nettype none

module tx_tlp_arbiter import pcie_fc_pkg::*, pcie_tlp_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [NUM_SRC-1:0] src_req,
    input  tlp_desc_t          src_desc [NUM_SRC],
    input  fc_vec_t            fc_av,
    output logic [NUM_SRC-1:0] src_grant,
    output fc_vec_t            fc_dec,
    output tx_tlp_t            tx_tlp
);

    // header and data credits seen by each source, indexed by source
    logic [FC_WIDTH-1:0]      hdr_av    [NUM_SRC];
    logic [FC_WIDTH-1:0]      data_av   [NUM_SRC];
    logic [FC_WIDTH-1:0]      data_need [NUM_SRC];
    logic [NUM_SRC-1:0]       eligible;

    // round-robin state holds the source granted last
    logic [SRC_IDX_WIDTH-1:0] last_q;
    logic [SRC_IDX_WIDTH-1:0] grant_idx;
    logic                     grant_any;

    // transmit bus registers
    logic                     valid_q;
    tlp_kind_e                kind_q;
    tlp_desc_t                desc_q;

    // each source maps onto the header and data class of its own kind
    assign hdr_av[TLP_POSTED]      = fc_av.ph;
    assign data_av[TLP_POSTED]     = fc_av.pd;
    assign hdr_av[TLP_NON_POSTED]  = fc_av.nph;
    assign data_av[TLP_NON_POSTED] = fc_av.npd;
    assign hdr_av[TLP_COMPLETION]  = fc_av.cplh;
    assign data_av[TLP_COMPLETION] = fc_av.cpld;

    // data credits needed are the length rounded up to whole credits
    // a zero length needs none, so header-only TLPs wait on header credit alone
    always_comb begin
        for (int i = 0; i < NUM_SRC; i++) begin
            data_need[i] = (FC_WIDTH'(src_desc[i].len) + FC_WIDTH'(FC_DW_PER_CREDIT - 1))
                           / FC_WIDTH'(FC_DW_PER_CREDIT);
        end
    end

    // a request may only win if one header credit and all of its data credits are there
    always_comb begin
        for (int i = 0; i < NUM_SRC; i++) begin
            eligible[i] = src_req[i] && (hdr_av[i] != '0) && (data_av[i] >= data_need[i]);
        end
    end

    // walk the sources starting just after the last winner
    // the last winner itself is checked at the end, so a lone requester still gets through
    always_comb begin
        int idx;
        grant_any = 1'b0;
        grant_idx = '0;
        for (int k = 1; k <= NUM_SRC; k++) begin
            idx = int'(last_q) + k;
            if (idx >= NUM_SRC) begin
                idx = idx - NUM_SRC;
            end
            if (!grant_any && eligible[idx]) begin
                grant_any = 1'b1;
                grant_idx = SRC_IDX_WIDTH'(idx);
            end
        end
    end

    // one-cycle grant pulse towards the winning source
    always_comb begin
        src_grant = '0;
        if (grant_any) begin
            src_grant[grant_idx] = 1'b1;
        end
    end

    // debit the winner's class in the grant cycle so the counters never lag a grant
    always_comb begin
        fc_dec = '0;
        if (grant_any) begin
            case (grant_idx)
                TLP_POSTED: begin
                    fc_dec.ph = FC_WIDTH'(1);
                    fc_dec.pd = data_need[TLP_POSTED];
                end
                TLP_NON_POSTED: begin
                    fc_dec.nph = FC_WIDTH'(1);
                    fc_dec.npd = data_need[TLP_NON_POSTED];
                end
                TLP_COMPLETION: begin
                    fc_dec.cplh = FC_WIDTH'(1);
                    fc_dec.cpld = data_need[TLP_COMPLETION];
                end
                default: begin
                    fc_dec = '0;
                end
            endcase
        end
    end

    // pointer starts on the last source so posted traffic goes first after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            last_q  <= SRC_IDX_WIDTH'(NUM_SRC - 1);
            valid_q <= 1'b0;
        end else begin
            valid_q <= grant_any;
            if (grant_any) begin
                last_q <= grant_idx;
            end
        end
    end

    // the winner's descriptor goes out the cycle after its grant
    always_ff @(posedge clk) begin
        if (grant_any) begin
            kind_q <= tlp_kind_e'(grant_idx);
            desc_q <= src_desc[grant_idx];
        end
    end

    assign tx_tlp = '{valid: valid_q, kind: kind_q, desc: desc_q};

    // the counters take at most one debit per cycle
    a_grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(src_grant))
        else $error("more than one grant at once: %b", src_grant);

    // a pulse to an idle source would be taken as the grant of its next request
    a_grant_to_req: assert property (@(posedge clk) disable iff (rst)
                                     (src_grant & ~src_req) == '0)
        else $error("grant %b without request %b", src_grant, src_req);

endmodule

`default_nettype wire

// ==== verilog/tx_fc_top.sv ====
// limit bus slots 0 to 5 feed the six counters; only credit holds back a request
`timescale 1ns/100ps
`default_nettype none

module tx_fc_top import pcie_fc_pkg::*, pcie_tlp_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic [FC_WIDTH-1:0] tx_cdts_limit,
    input  logic [2:0]          tx_cdts_limit_tdm_idx,
    input  logic [NUM_SRC-1:0]  src_req,
    input  tlp_desc_t           src_desc [NUM_SRC],
    output logic [NUM_SRC-1:0]  src_grant,
    output tx_tlp_t             tx_tlp,
    output fc_vec_t             fc_av
);

    // debits from the arbiter, one field per counter
    fc_vec_t fc_dec;

    // posted header credits
    tx_fc_counter #(.slot_index(FC_IDX_PH)) i_fc_ph (
        .clk                   (clk),
        .rst                   (rst),
        .tx_cdts_limit         (tx_cdts_limit),
        .tx_cdts_limit_tdm_idx (tx_cdts_limit_tdm_idx),
        .fc_dec                (fc_dec.ph),
        .fc_av                 (fc_av.ph)
    );

    // posted data credits
    tx_fc_counter #(.slot_index(FC_IDX_PD)) i_fc_pd (
        .clk                   (clk),
        .rst                   (rst),
        .tx_cdts_limit         (tx_cdts_limit),
        .tx_cdts_limit_tdm_idx (tx_cdts_limit_tdm_idx),
        .fc_dec                (fc_dec.pd),
        .fc_av                 (fc_av.pd)
    );

    // non-posted header credits
    tx_fc_counter #(.slot_index(FC_IDX_NPH)) i_fc_nph (
        .clk                   (clk),
        .rst                   (rst),
        .tx_cdts_limit         (tx_cdts_limit),
        .tx_cdts_limit_tdm_idx (tx_cdts_limit_tdm_idx),
        .fc_dec                (fc_dec.nph),
        .fc_av                 (fc_av.nph)
    );

    // non-posted data credits
    tx_fc_counter #(.slot_index(FC_IDX_NPD)) i_fc_npd (
        .clk                   (clk),
        .rst                   (rst),
        .tx_cdts_limit         (tx_cdts_limit),
        .tx_cdts_limit_tdm_idx (tx_cdts_limit_tdm_idx),
        .fc_dec                (fc_dec.npd),
        .fc_av                 (fc_av.npd)
    );

    // completion header credits
    tx_fc_counter #(.slot_index(FC_IDX_CPLH)) i_fc_cplh (
        .clk                   (clk),
        .rst                   (rst),
        .tx_cdts_limit         (tx_cdts_limit),
        .tx_cdts_limit_tdm_idx (tx_cdts_limit_tdm_idx),
        .fc_dec                (fc_dec.cplh),
        .fc_av                 (fc_av.cplh)
    );

    // completion data credits
    tx_fc_counter #(.slot_index(FC_IDX_CPLD)) i_fc_cpld (
        .clk                   (clk),
        .rst                   (rst),
        .tx_cdts_limit         (tx_cdts_limit),
        .tx_cdts_limit_tdm_idx (tx_cdts_limit_tdm_idx),
        .fc_dec                (fc_dec.cpld),
        .fc_av                 (fc_av.cpld)
    );

    // grants against the counts above and returns debits in the same cycle
    tx_tlp_arbiter i_arbiter (
        .clk       (clk),
        .rst       (rst),
        .src_req   (src_req),
        .src_desc  (src_desc),
        .fc_av     (fc_av),
        .src_grant (src_grant),
        .fc_dec    (fc_dec),
        .tx_tlp    (tx_tlp)
    );

endmodule

`default_nettype wire

// ==== verif/tx_fc_tb.sv ====
// run from the project root so the trace path resolves; outputs are sampled at the rising edge
`timescale 1ns/100ps
`default_nettype none

module tx_fc_tb import pcie_fc_pkg::*, pcie_tlp_pkg::*; ();

    localparam TRACE_FILE = "verif/tx_fc_trace.txt";
    localparam int LINE_BYTES = 128;
    // no counter listens to this slot, so it is the idle value of the limit bus
    localparam logic [2:0] IDLE_SLOT = 3'd7;

    logic                clk;
    logic                rst;
    logic [FC_WIDTH-1:0] tx_cdts_limit;
    logic [2:0]          tx_cdts_limit_tdm_idx;
    logic [NUM_SRC-1:0]  src_req;
    tlp_desc_t           src_desc [NUM_SRC];
    logic [NUM_SRC-1:0]  src_grant;
    tx_tlp_t             tx_tlp;
    fc_vec_t             fc_av;

    // requests raised by the trace and not yet granted
    logic [NUM_SRC-1:0]  pending;
    tlp_desc_t           pend_desc [NUM_SRC];
    // grants seen at the previous rising edge
    logic [NUM_SRC-1:0]  prev_grant;
    // TLPs seen on the bus that no expect line has taken yet
    tx_tlp_t             seen_tlps [$];
    int                  cycle_count;
    int                  cycle_limit;

    tx_fc_top i_dut (
        .clk                   (clk),
        .rst                   (rst),
        .tx_cdts_limit         (tx_cdts_limit),
        .tx_cdts_limit_tdm_idx (tx_cdts_limit_tdm_idx),
        .src_req               (src_req),
        .src_desc              (src_desc),
        .src_grant             (src_grant),
        .tx_tlp                (tx_tlp),
        .fc_av                 (fc_av)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic fail_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("ERROR: time %0t, %s expected %0d, got %0d", $time, name, expected, actual);
            fail_run();
        end
    endtask

    // one clock cycle; outputs at the rising edge still show the cycle that edge closes
    task automatic step();
        @(posedge clk);
        cycle_count++;
        // the bus carries a TLP in exactly the cycle after each grant
        if (!rst) begin
            check_value("tx_tlp.valid", int'(prev_grant != '0), int'(tx_tlp.valid));
        end
        prev_grant = src_grant;
        // a granted source drops its request in the next cycle
        pending = pending & ~src_grant;
        if (tx_tlp.valid) begin
            seen_tlps.push_back(tx_tlp);
        end
        if (cycle_count > cycle_limit) begin
            $display("timeout: the trace did not finish within %0d cycles", cycle_limit);
            fail_run();
        end
        @(negedge clk);
        tx_cdts_limit_tdm_idx = IDLE_SLOT;
        tx_cdts_limit = '0;
        src_req = pending;
        for (int i = 0; i < NUM_SRC; i++) begin
            src_desc[i] = pend_desc[i];
        end
    endtask

    task automatic require_fields(input int got, input int want,
                                  input logic [8*LINE_BYTES-1:0] line);
        if (got != want) begin
            $display("trace line has %0d fields instead of %0d: %0s", got, want, line);
            fail_run();
        end
    endtask

    // a source holds one request at a time, so a new one waits for the old grant
    task automatic raise_request(input int src, input int len, input int tag);
        if (src < 0 || src >= NUM_SRC) begin
            $display("trace names source %0d, which does not exist", src);
            fail_run();
        end
        while (pending[src]) begin
            step();
        end
        pending[src] = 1'b1;
        pend_desc[src].len = len[TLP_LEN_WIDTH-1:0];
        pend_desc[src].tag = tag[TLP_TAG_WIDTH-1:0];
        src_req = pending;
        src_desc[src] = pend_desc[src];
    endtask

    task automatic check_next_tlp(input int kind, input int len, input int tag);
        tx_tlp_t got;
        while (seen_tlps.size() == 0) begin
            step();
        end
        got = seen_tlps.pop_front();
        check_value("tx_tlp.kind", kind, int'(got.kind));
        check_value("tx_tlp.desc.len", len, int'(got.desc.len));
        check_value("tx_tlp.desc.tag", tag, int'(got.desc.tag));
    endtask

    task automatic check_credit(input logic [8*LINE_BYTES-1:0] field, input int value);
        string name;
        int    got;
        name = "";
        got = -1;
        if (field == "ph") begin
            name = "fc_av.ph";
            got = int'(fc_av.ph);
        end else if (field == "pd") begin
            name = "fc_av.pd";
            got = int'(fc_av.pd);
        end else if (field == "nph") begin
            name = "fc_av.nph";
            got = int'(fc_av.nph);
        end else if (field == "npd") begin
            name = "fc_av.npd";
            got = int'(fc_av.npd);
        end else if (field == "cplh") begin
            name = "fc_av.cplh";
            got = int'(fc_av.cplh);
        end else if (field == "cpld") begin
            name = "fc_av.cpld";
            got = int'(fc_av.cpld);
        end else begin
            $display("trace names credit field %0s, which does not exist", field);
            fail_run();
        end
        check_value(name, value, got);
    endtask

    // lines whose first word is a lone hash are comments, blank lines are skipped
    task automatic run_line(input logic [8*LINE_BYTES-1:0] line);
        logic [8*LINE_BYTES-1:0] cmd;
        logic [8*LINE_BYTES-1:0] sub;
        logic [8*LINE_BYTES-1:0] field;
        int a;
        int b;
        int c;
        int n;
        n = $sscanf(line, "%s", cmd);
        if (n >= 1 && cmd != "#") begin
            if (cmd == "L") begin
                n = $sscanf(line, "%s %d %d", cmd, a, b);
                require_fields(n, 3, line);
                tx_cdts_limit_tdm_idx = a[2:0];
                tx_cdts_limit = b[FC_WIDTH-1:0];
                step();
            end else if (cmd == "R") begin
                n = $sscanf(line, "%s %d %d %d", cmd, a, b, c);
                require_fields(n, 4, line);
                raise_request(a, b, c);
            end else if (cmd == "W") begin
                n = $sscanf(line, "%s %d", cmd, a);
                require_fields(n, 2, line);
                repeat (a) step();
            end else if (cmd == "E") begin
                n = $sscanf(line, "%s %s", cmd, sub);
                if (sub == "T") begin
                    n = $sscanf(line, "%s %s %d %d %d", cmd, sub, a, b, c);
                    require_fields(n, 5, line);
                    check_next_tlp(a, b, c);
                end else if (sub == "A") begin
                    n = $sscanf(line, "%s %s %s %d", cmd, sub, field, a);
                    require_fields(n, 4, line);
                    check_credit(field, a);
                end else begin
                    $display("trace expect line not understood: %0s", line);
                    fail_run();
                end
            end else begin
                $display("trace line not understood: %0s", line);
                fail_run();
            end
        end
    endtask

    initial begin
        int                      fd;
        int                      line_count;
        logic [8*LINE_BYTES-1:0] line;
        rst = 1'b1;
        tx_cdts_limit = '0;
        tx_cdts_limit_tdm_idx = IDLE_SLOT;
        src_req = '0;
        pending = '0;
        prev_grant = '0;
        for (int i = 0; i < NUM_SRC; i++) begin
            src_desc[i] = '0;
            pend_desc[i] = '0;
        end
        cycle_count = 0;
        cycle_limit = 100;
        line_count = 0;

        // the cycle budget grows with the length of the trace
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the trace file %0s", TRACE_FILE);
            fail_run();
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) > 0) begin
                line_count++;
            end
        end
        $fclose(fd);
        cycle_limit = 20 * line_count + 100;

        repeat (10) step();
        rst = 1'b0;
        check_value("tx_tlp.valid", 0, int'(tx_tlp.valid));
        check_value("src_grant", 0, int'(src_grant));

        fd = $fopen(TRACE_FILE, "r");
        while (!$feof(fd)) begin
            line = '0;
            if ($fgets(line, fd) > 0) begin
                run_line(line);
            end
        end
        $fclose(fd);

        // anything left over went out on the bus without a matching expect line
        assert (seen_tlps.size() == 0) else begin
            $display("%0d TLPs appeared on the bus that the trace never expected",
                     seen_tlps.size());
            fail_run();
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
verilog/pcie_fc_pkg.sv
verilog/pcie_tlp_pkg.sv
verilog/tx_fc_counter.sv
verilog/tx_tlp_arbiter.sv
verilog/tx_fc_top.sv
verif/tx_fc_tb.sv

// ==== verif/tx_fc_trace.txt ====
# L slot limit | R source length tag | W cycles | E T kind length tag | E A field value
# slots 0..5 are ph pd nph npd cplh cpld, sources and kinds are 0 posted 1 non-posted 2 completion
# reset leaves every count at zero and the bus idle
E A ph 0
E A cpld 0
W 4
E A npd 0
# first round of limits sets each capacity
L 0 8
L 1 64
L 2 8
L 3 16
L 4 8
L 5 64
W 2
E A ph 8
E A pd 64
E A nph 8
E A npd 16
E A cplh 8
E A cpld 64
# posted 16 dwords takes one header and four data credits
R 0 16 17
E T 0 16 17
W 2
E A ph 7
E A pd 60
E A nph 8
E A npd 16
E A cplh 8
E A cpld 64
# non-posted 48 dwords leaves four data credits
R 1 48 33
E T 1 48 33
# 32 dwords need eight data credits and must wait
R 1 32 34
W 8
E A nph 7
E A npd 4
# raising the limit from 16 to 28 frees the waiting request
L 3 28
E T 1 32 34
W 2
E A npd 8
E A nph 6
# a lone completion request without data
R 2 0 48
E T 2 0 48
E A cplh 7
# all three sources keep requesting and are served in turn
R 0 4 65
R 1 0 66
R 2 8 67
R 0 4 68
R 1 0 69
R 2 8 70
E T 0 4 65
E T 1 0 66
E T 2 8 67
E T 0 4 68
E T 1 0 69
E T 2 8 70
W 2
E A ph 5
E A pd 58
E A nph 4
E A npd 8
E A cplh 5
E A cpld 60
# increases beyond what was consumed clamp at the capacity
L 0 18
L 1 100
L 4 10
W 2
E A ph 8
E A pd 64
E A cplh 7
E A cpld 60
R 0 8 80
E T 0 8 80
W 2
E A ph 7
E A pd 62
L 0 19
W 2
E A ph 8
